//--- l2data_geom_pkg.sv
// geometry is fixed here; bank rows hold {way, set, upper beat bit}, so changing a size means revisiting bank addressing
package l2data_geom_pkg;

  localparam int NUM_WAYS   = 4;
  localparam int NUM_SETS   = 512;
  localparam int NUM_BANKS  = 4;
  localparam int LINE_BEATS = 8;

  // rows per bank, words of a line spread over all banks
  localparam int BANK_ROWS = NUM_WAYS * NUM_SETS * LINE_BEATS / NUM_BANKS;

  // 64-bit data word
  typedef logic [63:0] word_t;

  // byte-write mask
  typedef logic [7:0] wmask_t;

  // address of a word and of a line
  typedef logic [31:3] word_addr_t;
  typedef logic [31:6] line_addr_t;

  // one-hot way and bank
  typedef logic [3:0] way_oh_t;
  typedef logic [3:0] bank_oh_t;

  // way index, set, upper beat bit
  typedef logic [11:0] bank_addr_t;

  typedef logic [2:0] beat_t;

  typedef logic [4:0] snoop_tag_t;

endpackage

//--- l2data_cmd_pkg.sv
// encodings shared with the tag unit and the bus-transaction unit; a request CMD carries a bus_cmd_t
package l2data_cmd_pkg;

  // request operation from the tag unit
  typedef enum logic [1:0] {
    CMD   = 2'd0,
    READ  = 2'd1,
    WRITE = 2'd2
  } req_op_t;

  // bus command, FLUSH is the only one with data
  typedef enum logic [2:0] {
    BUSRD   = 3'd0,
    BUSRDX  = 3'd1,
    BUSUPGR = 3'd2,
    FLUSH   = 3'd3
  } bus_cmd_t;

  // which port owns the banks this cycle
  typedef enum logic [1:0] {
    NONE  = 2'd0,
    REQ   = 2'd1,
    SNOOP = 2'd2
  } src_t;

endpackage

//--- l2bank.sv
// single-port bank, two-cycle read; rdata only changes after a read and holds until the next read
module l2bank
  import l2data_geom_pkg::*;
(
  input  logic       clk,
  input  logic       en,
  input  logic       wen,
  input  bank_addr_t addr,
  input  wmask_t     wmask,
  input  word_t      wdata,
  output word_t      rdata
);

  word_t      mem [BANK_ROWS];
  bank_addr_t addr_q;
  logic       rd_q;

  // byte-masked write
  always_ff @(posedge clk) begin
    if (en && wen) begin
      for (int b = 0; b < 8; b++) begin
        if (wmask[b]) begin
          mem[addr][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // first read cycle registers the row
  always_ff @(posedge clk) begin
    rd_q <= en & ~wen;
    if (en && !wen) begin
      addr_q <= addr;
    end
  end

  // second cycle registers the word
  always_ff @(posedge clk) begin
    if (rd_q) begin
      rdata <= mem[addr_q];
    end
  end

endmodule

//--- l2data_issue.sv
// one request and one snoop held at stage 0; fill data must arrive on the cycles right after the snoop handshake
module l2data_issue
  import l2data_geom_pkg::*;
  import l2data_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       l2tag_req_valid,
  input  req_op_t    l2tag_req_op,
  input  bus_cmd_t   l2tag_req_cmd,
  input  word_addr_t l2tag_req_addr,
  input  way_oh_t    l2tag_req_way,
  input  wmask_t     l2tag_req_wmask,
  input  word_t      l2tag_req_wdata,
  output logic       l2data_req_ready,
  input  logic       l2tag_snoop_valid,
  input  snoop_tag_t l2tag_snoop_tag,
  input  line_addr_t l2tag_snoop_addr,
  input  way_oh_t    l2tag_snoop_way,
  input  logic       l2tag_snoop_wen,
  input  word_t      l2tag_snoop_wdata,
  output logic       l2data_snoop_ready,
  input  logic       trans_req_ready,
  input  logic       trans_snoop_ready,
  input  logic       stall,
  output src_t       bank_src,
  output bank_oh_t   bank_sel,
  output bank_addr_t bank_addr,
  output logic       bank_wen,
  output wmask_t     bank_wmask,
  output word_t      bank_wdata,
  output logic       launch_req_valid,
  output req_op_t    launch_req_op,
  output bus_cmd_t   launch_cmd,
  output line_addr_t launch_line,
  output bank_oh_t   launch_req_bank,
  output logic       launch_snoop_valid,
  output snoop_tag_t launch_snoop_tag,
  output line_addr_t launch_snoop_line,
  output bank_oh_t   launch_snoop_bank,
  output logic       s0_busy
);

  logic       s0_req_valid;
  req_op_t    s0_req_op;
  bus_cmd_t   s0_req_cmd;
  word_addr_t s0_req_addr;
  way_oh_t    s0_req_way;
  wmask_t     s0_req_wmask;
  word_t      s0_req_wdata;
  beat_t      req_beat;

  logic       s0_snoop_valid;
  snoop_tag_t s0_snoop_tag;
  line_addr_t s0_snoop_addr;
  way_oh_t    s0_snoop_way;
  logic       s0_snoop_wen;
  beat_t      snoop_beat;

  // a request read sitting in pipe stage 1
  logic       rd_s1;

  logic       req_flush;
  logic       req_last;
  logic       snoop_last;
  logic       req_go;
  logic       req_issue;
  logic       snoop_issue;
  bank_oh_t   req_sel;
  bank_oh_t   snoop_sel;
  bank_addr_t req_row;
  bank_addr_t snoop_row;

  function automatic logic [1:0] way_idx(way_oh_t oh);
    way_idx = {oh[2] | oh[3], oh[1] | oh[3]};
  endfunction

  assign req_flush  = (s0_req_op == CMD) && (s0_req_cmd == FLUSH);
  assign req_last   = (req_beat == beat_t'(LINE_BEATS - 1));
  assign snoop_last = (snoop_beat == beat_t'(LINE_BEATS - 1));

  // a started flush owns the banks until its last beat
  assign snoop_issue = s0_snoop_valid && (req_beat == '0) &&
                       (s0_snoop_wen || trans_snoop_ready || (snoop_beat != '0));

  // flush start also waits for stage 1 to hold no read that could stall behind it
  always_comb begin
    case (s0_req_op)
      READ:    req_go = !stall;
      WRITE:   req_go = 1'b1;
      default: req_go = req_flush ? ((req_beat != '0) ||
                                     (trans_req_ready && !stall && !rd_s1))
                                  : (trans_req_ready && !stall);
    endcase
  end

  assign req_issue = s0_req_valid && req_go && !snoop_issue;

  assign req_sel   = bank_oh_t'(1) << (req_flush ? req_beat[1:0] : s0_req_addr[4:3]);
  assign req_row   = {way_idx(s0_req_way), s0_req_addr[14:6],
                      req_flush ? req_beat[2] : s0_req_addr[5]};
  assign snoop_sel = bank_oh_t'(1) << snoop_beat[1:0];
  assign snoop_row = {way_idx(s0_snoop_way), s0_snoop_addr[14:6], snoop_beat[2]};

  assign l2data_req_ready = !s0_req_valid || (req_issue && (!req_flush || req_last));

  // no new snoop while a flush continues, a fill cannot wait for its data
  assign l2data_snoop_ready = (!s0_snoop_valid || (snoop_issue && snoop_last)) &&
                              !(req_issue && req_flush && !req_last);

  always_comb begin
    bank_src   = NONE;
    bank_sel   = '0;
    bank_addr  = req_row;
    bank_wen   = 1'b0;
    bank_wmask = s0_req_wmask;
    bank_wdata = s0_req_wdata;
    if (snoop_issue) begin
      bank_src   = SNOOP;
      bank_sel   = snoop_sel;
      bank_addr  = snoop_row;
      bank_wen   = s0_snoop_wen;
      bank_wdata = l2tag_snoop_wdata;
    end else if (req_issue) begin
      bank_src = REQ;
      // plain bus commands touch no bank
      bank_sel = (s0_req_op == CMD && !req_flush) ? '0 : req_sel;
      bank_wen = (s0_req_op == WRITE);
    end
  end

  assign launch_req_valid   = req_issue && (s0_req_op != WRITE);
  assign launch_req_op      = s0_req_op;
  assign launch_cmd         = s0_req_cmd;
  assign launch_line        = s0_req_addr[31:6];
  assign launch_req_bank    = req_sel;
  assign launch_snoop_valid = snoop_issue && !s0_snoop_wen;
  assign launch_snoop_tag   = s0_snoop_tag;
  assign launch_snoop_line  = s0_snoop_addr;
  assign launch_snoop_bank  = snoop_sel;
  assign s0_busy            = s0_req_valid || s0_snoop_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      s0_req_valid   <= 1'b0;
      s0_snoop_valid <= 1'b0;
      req_beat       <= '0;
      snoop_beat     <= '0;
      rd_s1          <= 1'b0;
    end else begin
      if (l2data_req_ready) begin
        s0_req_valid <= l2tag_req_valid;
      end
      if (l2data_snoop_ready) begin
        s0_snoop_valid <= l2tag_snoop_valid;
      end
      // counters wrap to zero after the last beat
      if (req_issue && req_flush) begin
        req_beat <= req_beat + 1'b1;
      end
      if (snoop_issue) begin
        snoop_beat <= snoop_beat + 1'b1;
      end
      if (!stall) begin
        rd_s1 <= launch_req_valid && (s0_req_op == READ);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (l2data_req_ready && l2tag_req_valid) begin
      s0_req_op    <= l2tag_req_op;
      s0_req_cmd   <= l2tag_req_cmd;
      s0_req_addr  <= l2tag_req_addr;
      s0_req_way   <= l2tag_req_way;
      s0_req_wmask <= l2tag_req_wmask;
      s0_req_wdata <= l2tag_req_wdata;
    end
    if (l2data_snoop_ready && l2tag_snoop_valid) begin
      s0_snoop_tag  <= l2tag_snoop_tag;
      s0_snoop_addr <= l2tag_snoop_addr;
      s0_snoop_way  <= l2tag_snoop_way;
      s0_snoop_wen  <= l2tag_snoop_wen;
    end
  end

endmodule

//--- l2data_banks.sv
// four interleaved banks; at most one access per cycle, snoop fills always write whole words
module l2data_banks
  import l2data_geom_pkg::*;
  import l2data_cmd_pkg::*;
(
  input  logic       clk,
  input  src_t       bank_src,
  input  bank_oh_t   bank_sel,
  input  bank_addr_t bank_addr,
  input  logic       bank_wen,
  input  wmask_t     bank_wmask,
  input  word_t      bank_wdata,
  output word_t      bank_rdata0,
  output word_t      bank_rdata1,
  output word_t      bank_rdata2,
  output word_t      bank_rdata3
);

  bank_oh_t bank_en;
  wmask_t   wmask;
  word_t    rdata [NUM_BANKS];

  assign bank_en = (bank_src != NONE) ? bank_sel : '0;

  // fill beats carry no mask
  assign wmask = (bank_src == SNOOP) ? '1 : bank_wmask;

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    l2bank u_bank (
      .clk   (clk),
      .en    (bank_en[i]),
      .wen   (bank_wen),
      .addr  (bank_addr),
      .wmask (wmask),
      .wdata (bank_wdata),
      .rdata (rdata[i])
    );
  end

  assign bank_rdata0 = rdata[0];
  assign bank_rdata1 = rdata[1];
  assign bank_rdata2 = rdata[2];
  assign bank_rdata3 = rdata[3];

endmodule

//--- l2data_pipe.sv
// read tracking after issue; a held response freezes the request stages only, snoop reads never stall
module l2data_pipe
  import l2data_geom_pkg::*;
  import l2data_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       launch_req_valid,
  input  req_op_t    launch_req_op,
  input  bus_cmd_t   launch_cmd,
  input  line_addr_t launch_line,
  input  bank_oh_t   launch_req_bank,
  input  logic       launch_snoop_valid,
  input  snoop_tag_t launch_snoop_tag,
  input  line_addr_t launch_snoop_line,
  input  bank_oh_t   launch_snoop_bank,
  input  word_t      bank_rdata0,
  input  word_t      bank_rdata1,
  input  word_t      bank_rdata2,
  input  word_t      bank_rdata3,
  input  logic       resp_ready,
  output logic       stall,
  output logic       l2data_req_valid,
  output bus_cmd_t   l2data_req_cmd,
  output line_addr_t l2data_req_addr,
  output word_t      l2data_req_data,
  output logic       l2data_snoop_valid,
  output snoop_tag_t l2data_snoop_tag,
  output line_addr_t l2data_snoop_addr,
  output word_t      l2data_snoop_data,
  output logic       l2_resp_valid,
  output word_t      l2_resp_rdata,
  output logic       pipe_busy
);

  logic       s1_valid, s1_arr, s1_have;
  req_op_t    s1_op;
  bus_cmd_t   s1_cmd;
  line_addr_t s1_line;
  bank_oh_t   s1_bank;
  word_t      s1_word;

  logic       s2_valid, s2_have;
  req_op_t    s2_op;
  bus_cmd_t   s2_cmd;
  line_addr_t s2_line;
  bank_oh_t   s2_bank;
  word_t      s2_word;

  logic       ss1_valid, ss2_valid;
  snoop_tag_t ss1_tag, ss2_tag;
  line_addr_t ss1_line, ss2_line;
  bank_oh_t   ss1_bank, ss2_bank;

  word_t      s1_bank_word;
  word_t      s2_data;

  function automatic word_t pick(bank_oh_t sel, word_t w0, word_t w1, word_t w2, word_t w3);
    pick = ({64{sel[0]}} & w0) | ({64{sel[1]}} & w1) |
           ({64{sel[2]}} & w2) | ({64{sel[3]}} & w3);
  endfunction

  assign s1_bank_word = pick(s1_bank, bank_rdata0, bank_rdata1, bank_rdata2, bank_rdata3);

  // bank word is live only in the first stage-2 cycle, later from the capture
  assign s2_data = s2_have ? s2_word
                           : pick(s2_bank, bank_rdata0, bank_rdata1, bank_rdata2, bank_rdata3);

  assign stall = s2_valid && (s2_op == READ) && !resp_ready;

  assign l2_resp_valid    = s2_valid && (s2_op == READ);
  assign l2_resp_rdata    = s2_data;
  assign l2data_req_valid = s2_valid && (s2_op == CMD);
  assign l2data_req_cmd   = s2_cmd;
  assign l2data_req_addr  = s2_line;
  assign l2data_req_data  = s2_data;

  assign l2data_snoop_valid = ss2_valid;
  assign l2data_snoop_tag   = ss2_tag;
  assign l2data_snoop_addr  = ss2_line;
  assign l2data_snoop_data  = pick(ss2_bank, bank_rdata0, bank_rdata1, bank_rdata2, bank_rdata3);

  assign pipe_busy = s1_valid || s2_valid || ss1_valid || ss2_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      ss1_valid <= 1'b0;
      ss2_valid <= 1'b0;
    end else begin
      ss1_valid <= launch_snoop_valid;
      ss2_valid <= ss1_valid;
      if (!stall) begin
        s1_valid <= launch_req_valid;
        s2_valid <= s1_valid;
      end
    end
  end

  // request stages with word capture while frozen
  always_ff @(posedge clk) begin
    if (!stall) begin
      s1_op   <= launch_req_op;
      s1_cmd  <= launch_cmd;
      s1_line <= launch_line;
      s1_bank <= launch_req_bank;
      s1_arr  <= 1'b0;
      s1_have <= 1'b0;
      s2_op   <= s1_op;
      s2_cmd  <= s1_cmd;
      s2_line <= s1_line;
      s2_bank <= s1_bank;
      s2_have <= s1_have || s1_arr;
      s2_word <= s1_have ? s1_word : s1_bank_word;
    end else begin
      if (!s2_have) begin
        s2_word <= s2_data;
        s2_have <= 1'b1;
      end
      // s1 word shows up one cycle after the freeze began
      s1_arr <= 1'b1;
      if (s1_arr && !s1_have) begin
        s1_word <= s1_bank_word;
        s1_have <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    ss1_tag  <= launch_snoop_tag;
    ss1_line <= launch_snoop_line;
    ss1_bank <= launch_snoop_bank;
    ss2_tag  <= ss1_tag;
    ss2_line <= ss1_line;
    ss2_bank <= ss1_bank;
  end

endmodule

//--- l2data.sv
// data array of an L2 slice; tag lookup, invalidation matching and error responses live elsewhere
module l2data
  import l2data_geom_pkg::*;
  import l2data_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       l2tag_req_valid,
  input  req_op_t    l2tag_req_op,
  input  bus_cmd_t   l2tag_req_cmd,
  input  word_addr_t l2tag_req_addr,
  input  way_oh_t    l2tag_req_way,
  input  wmask_t     l2tag_req_wmask,
  input  word_t      l2tag_req_wdata,
  output logic       l2data_req_ready,
  input  logic       l2tag_snoop_valid,
  input  snoop_tag_t l2tag_snoop_tag,
  input  line_addr_t l2tag_snoop_addr,
  input  way_oh_t    l2tag_snoop_way,
  input  logic       l2tag_snoop_wen,
  input  word_t      l2tag_snoop_wdata,
  output logic       l2data_snoop_ready,
  output logic       l2data_req_valid,
  output bus_cmd_t   l2data_req_cmd,
  output line_addr_t l2data_req_addr,
  output word_t      l2data_req_data,
  input  logic       l2trans_req_ready,
  output logic       l2data_snoop_valid,
  output snoop_tag_t l2data_snoop_tag,
  output line_addr_t l2data_snoop_addr,
  output word_t      l2data_snoop_data,
  input  logic       l2trans_snoop_ready,
  output logic       l2_resp_valid,
  output word_t      l2_resp_rdata,
  input  logic       resp_ready,
  output logic       l2data_idle
);

  logic       stall;
  src_t       bank_src;
  bank_oh_t   bank_sel;
  bank_addr_t bank_addr;
  logic       bank_wen;
  wmask_t     bank_wmask;
  word_t      bank_wdata;
  word_t      bank_rdata0, bank_rdata1, bank_rdata2, bank_rdata3;

  logic       launch_req_valid;
  req_op_t    launch_req_op;
  bus_cmd_t   launch_cmd;
  line_addr_t launch_line;
  bank_oh_t   launch_req_bank;
  logic       launch_snoop_valid;
  snoop_tag_t launch_snoop_tag;
  line_addr_t launch_snoop_line;
  bank_oh_t   launch_snoop_bank;

  logic       s0_busy;
  logic       pipe_busy;

  l2data_issue u_issue (
    .clk, .rst,
    .l2tag_req_valid, .l2tag_req_op, .l2tag_req_cmd, .l2tag_req_addr,
    .l2tag_req_way, .l2tag_req_wmask, .l2tag_req_wdata, .l2data_req_ready,
    .l2tag_snoop_valid, .l2tag_snoop_tag, .l2tag_snoop_addr, .l2tag_snoop_way,
    .l2tag_snoop_wen, .l2tag_snoop_wdata, .l2data_snoop_ready,
    .trans_req_ready   (l2trans_req_ready),
    .trans_snoop_ready (l2trans_snoop_ready),
    .stall,
    .bank_src, .bank_sel, .bank_addr, .bank_wen, .bank_wmask, .bank_wdata,
    .launch_req_valid, .launch_req_op, .launch_cmd, .launch_line, .launch_req_bank,
    .launch_snoop_valid, .launch_snoop_tag, .launch_snoop_line, .launch_snoop_bank,
    .s0_busy
  );

  l2data_banks u_banks (
    .clk,
    .bank_src, .bank_sel, .bank_addr, .bank_wen, .bank_wmask, .bank_wdata,
    .bank_rdata0, .bank_rdata1, .bank_rdata2, .bank_rdata3
  );

  l2data_pipe u_pipe (
    .clk, .rst,
    .launch_req_valid, .launch_req_op, .launch_cmd, .launch_line, .launch_req_bank,
    .launch_snoop_valid, .launch_snoop_tag, .launch_snoop_line, .launch_snoop_bank,
    .bank_rdata0, .bank_rdata1, .bank_rdata2, .bank_rdata3,
    .resp_ready, .stall,
    .l2data_req_valid, .l2data_req_cmd, .l2data_req_addr, .l2data_req_data,
    .l2data_snoop_valid, .l2data_snoop_tag, .l2data_snoop_addr, .l2data_snoop_data,
    .l2_resp_valid, .l2_resp_rdata,
    .pipe_busy
  );

  assign l2data_idle = !(s0_busy || pipe_busy);

endmodule

//--- tb_clkgen.sv
// free-running clock with a 4 ns period, starts low at time zero
module tb_clkgen (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

endmodule

//--- l2data_asserts.sv
// protocol checks on the l2data outputs, bound into the DUT by the testbench; idle while rst is high
module l2data_asserts
  import l2data_geom_pkg::*;
  import l2data_cmd_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input logic     l2_resp_valid,
  input word_t    l2_resp_rdata,
  input logic     resp_ready,
  input logic     l2data_req_valid,
  input bus_cmd_t l2data_req_cmd,
  input logic     l2data_snoop_valid
);

  timeunit 1ns;
  timeprecision 100ps;

  beat_t flush_beat;
  beat_t snoop_beat;

  // beat position within the current burst
  always_ff @(posedge clk) begin
    if (rst) begin
      flush_beat <= '0;
      snoop_beat <= '0;
    end else begin
      if (l2data_req_valid && (l2data_req_cmd == FLUSH)) begin
        flush_beat <= flush_beat + 1'b1;
      end
      if (l2data_snoop_valid) begin
        snoop_beat <= snoop_beat + 1'b1;
      end
    end
  end

  resp_held: assert property (@(posedge clk) disable iff (rst)
    (l2_resp_valid && !resp_ready) |=> (l2_resp_valid && $stable(l2_resp_rdata)))
    else $error("response dropped or changed while held");

  flush_run: assert property (@(posedge clk) disable iff (rst)
    (l2data_req_valid && (l2data_req_cmd == FLUSH) && (flush_beat != 3'd7))
    |=> (l2data_req_valid && (l2data_req_cmd == FLUSH)))
    else $error("flush burst broken before its eighth beat");

  snoop_run: assert property (@(posedge clk) disable iff (rst)
    (l2data_snoop_valid && (snoop_beat != 3'd7)) |=> l2data_snoop_valid)
    else $error("snoop read burst broken before its eighth beat");

endmodule

//--- l2data_tb.sv
// sets 0,131,262,393 are filled first; each round snoops use one way that requests leave alone
module l2data_tb
  import l2data_geom_pkg::*;
  import l2data_cmd_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_LINES      = 16;
  localparam int ROUNDS         = 6;
  localparam int ROUND_REQS     = 40;
  localparam int ROUND_SNOOPS   = 5;
  localparam int NUM_OPS        = 2 * NUM_LINES + ROUNDS * (ROUND_REQS + ROUND_SNOOPS);
  localparam int TIMEOUT_CYCLES = NUM_OPS * 40 + 2000;

  logic       clk;
  logic       rst;
  logic       l2tag_req_valid;
  req_op_t    l2tag_req_op;
  bus_cmd_t   l2tag_req_cmd;
  word_addr_t l2tag_req_addr;
  way_oh_t    l2tag_req_way;
  wmask_t     l2tag_req_wmask;
  word_t      l2tag_req_wdata;
  logic       l2data_req_ready;
  logic       l2tag_snoop_valid;
  snoop_tag_t l2tag_snoop_tag;
  line_addr_t l2tag_snoop_addr;
  way_oh_t    l2tag_snoop_way;
  logic       l2tag_snoop_wen;
  word_t      l2tag_snoop_wdata;
  logic       l2data_snoop_ready;
  logic       l2data_req_valid;
  bus_cmd_t   l2data_req_cmd;
  line_addr_t l2data_req_addr;
  word_t      l2data_req_data;
  logic       l2trans_req_ready;
  logic       l2data_snoop_valid;
  snoop_tag_t l2data_snoop_tag;
  line_addr_t l2data_snoop_addr;
  word_t      l2data_snoop_data;
  logic       l2trans_snoop_ready;
  logic       l2_resp_valid;
  word_t      l2_resp_rdata;
  logic       resp_ready;
  logic       l2data_idle;

  logic [15:0] lfsr_state = 16'd21;
  int          cycles = 0;
  // reference data, indexed by {way, set, word}
  word_t       model [logic [13:0]];
  word_t       fill_buf [LINE_BEATS];
  int          fill_left;
  logic [1:0]  req_way_idx;
  logic [1:0]  snoop_way_idx;
  logic [1:0]  free_way;
  logic        req_fire;
  logic        snoop_fire;
  logic        prefill;
  int          pf_idx;
  int          reqs_left;
  int          snoops_left;

  word_t      exp_resp [$];
  bus_cmd_t   exp_bus_cmd [$];
  line_addr_t exp_bus_addr [$];
  word_t      exp_bus_data [$];
  logic       exp_bus_flush [$];
  snoop_tag_t exp_sn_tag [$];
  line_addr_t exp_sn_addr [$];
  word_t      exp_sn_data [$];

  tb_clkgen u_clkgen (.clk);

  l2data uut (.*);

  bind l2data l2data_asserts u_asserts (
    .clk, .rst, .l2_resp_valid, .l2_resp_rdata, .resp_ready,
    .l2data_req_valid, .l2data_req_cmd, .l2data_snoop_valid
  );

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [63:0] lfsr_bits(input int n);
    logic [63:0] v;
    logic        fb;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      v          = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic logic [8:0] set_of(input logic [1:0] s);
    return 9'(s) * 9'd131;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped after a failure");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %s got=%h exp=%h", name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic accept_request();
    logic [13:0] key;
    word_t       w;
    int          b;
    key = {req_way_idx, l2tag_req_addr[14:3]};
    case (l2tag_req_op)
      WRITE: begin
        w = model[key];
        for (b = 0; b < 8; b++) begin
          if (l2tag_req_wmask[b]) begin
            w[8*b +: 8] = l2tag_req_wdata[8*b +: 8];
          end
        end
        model[key] = w;
      end
      READ: exp_resp.push_back(model[key]);
      default: begin
        // a flush reads the whole line, other commands carry no data
        for (b = 0; b < ((l2tag_req_cmd == FLUSH) ? LINE_BEATS : 1); b++) begin
          exp_bus_cmd.push_back(l2tag_req_cmd);
          exp_bus_addr.push_back(l2tag_req_addr[31:6]);
          exp_bus_data.push_back(model[{req_way_idx, l2tag_req_addr[14:6], 3'(b)}]);
          exp_bus_flush.push_back(l2tag_req_cmd == FLUSH);
        end
      end
    endcase
  endtask

  task automatic accept_snoop();
    logic [10:0] line;
    int          b;
    line = {snoop_way_idx, l2tag_snoop_addr[14:6]};
    for (b = 0; b < LINE_BEATS; b++) begin
      if (l2tag_snoop_wen) begin
        fill_buf[b]             = lfsr_bits(64);
        model[{line, 3'(b)}]    = fill_buf[b];
      end else begin
        exp_sn_tag.push_back(l2tag_snoop_tag);
        exp_sn_addr.push_back(l2tag_snoop_addr);
        exp_sn_data.push_back(model[{line, 3'(b)}]);
      end
    end
    fill_left = l2tag_snoop_wen ? LINE_BEATS : 0;
  endtask

  task automatic check_outputs();
    word_t d;
    logic  f;
    if (l2_resp_valid && resp_ready) begin
      if (exp_resp.size() == 0) begin
        stop_run("response seen with no read outstanding");
      end else begin
        check_value("l2_resp_rdata", l2_resp_rdata, exp_resp.pop_front());
      end
    end
    if (l2data_req_valid) begin
      if (exp_bus_cmd.size() == 0) begin
        stop_run("bus beat seen with no flush or command outstanding");
      end else begin
        d = exp_bus_data.pop_front();
        f = exp_bus_flush.pop_front();
        check_value("l2data_req_cmd", l2data_req_cmd, exp_bus_cmd.pop_front());
        check_value("l2data_req_addr", l2data_req_addr, exp_bus_addr.pop_front());
        if (f) begin
          check_value("l2data_req_data", l2data_req_data, d);
        end
      end
    end
    if (l2data_snoop_valid) begin
      if (exp_sn_tag.size() == 0) begin
        stop_run("snoop data beat seen with no snoop read outstanding");
      end else begin
        check_value("l2data_snoop_tag", l2data_snoop_tag, exp_sn_tag.pop_front());
        check_value("l2data_snoop_addr", l2data_snoop_addr, exp_sn_addr.pop_front());
        check_value("l2data_snoop_data", l2data_snoop_data, exp_sn_data.pop_front());
      end
    end
  endtask

  task automatic next_request();
    logic [2:0] pick;
    logic [1:0] c;
    pick        = 3'(lfsr_bits(3));
    c           = 2'(lfsr_bits(2));
    req_way_idx = 2'(lfsr_bits(2));
    // keep clear of the snoop way
    if (req_way_idx == free_way) begin
      req_way_idx = req_way_idx + 2'd1;
    end
    l2tag_req_valid = 1'b1;
    l2tag_req_way   = way_oh_t'(4'b0001 << req_way_idx);
    l2tag_req_addr  = {9'd0, 8'(lfsr_bits(8)), set_of(2'(lfsr_bits(2))), 3'(lfsr_bits(3))};
    l2tag_req_wmask = 8'(lfsr_bits(8));
    l2tag_req_wdata = lfsr_bits(64);
    l2tag_req_cmd   = BUSRD;
    if (pick < 3'd3) begin
      l2tag_req_op = WRITE;
    end else if (pick < 3'd6) begin
      l2tag_req_op = READ;
    end else begin
      l2tag_req_op  = CMD;
      l2tag_req_cmd = (pick == 3'd6) ? FLUSH : bus_cmd_t'({1'b0, (c == 2'd3) ? 2'd0 : c});
    end
    reqs_left--;
  endtask

  task automatic next_snoop();
    logic [1:0] set_sel;
    if (prefill) begin
      // first pass fills every line, second reads them back
      snoop_way_idx   = 2'(pf_idx >> 2);
      set_sel         = 2'(pf_idx);
      l2tag_snoop_wen = (pf_idx < NUM_LINES);
      pf_idx++;
    end else begin
      snoop_way_idx   = free_way;
      set_sel         = 2'(lfsr_bits(2));
      l2tag_snoop_wen = 1'(lfsr_bits(1));
    end
    l2tag_snoop_valid = 1'b1;
    l2tag_snoop_tag   = 5'(lfsr_bits(5));
    l2tag_snoop_way   = way_oh_t'(4'b0001 << snoop_way_idx);
    l2tag_snoop_addr  = {9'd0, 8'(lfsr_bits(8)), set_of(set_sel)};
    snoops_left--;
  endtask

  task automatic drive_inputs();
    resp_ready          = (lfsr_bits(2) != 0);
    l2trans_req_ready   = (lfsr_bits(2) != 0);
    l2trans_snoop_ready = (lfsr_bits(2) != 0);
    if (fill_left > 0) begin
      l2tag_snoop_wdata = fill_buf[LINE_BEATS - fill_left];
      fill_left--;
    end
    if (!l2tag_req_valid || req_fire) begin
      l2tag_req_valid = 1'b0;
      if ((reqs_left > 0) && (lfsr_bits(2) != 0)) begin
        next_request();
      end
    end
    if (!l2tag_snoop_valid || snoop_fire) begin
      l2tag_snoop_valid = 1'b0;
      if ((snoops_left > 0) && (prefill || (lfsr_bits(3) == 0))) begin
        next_snoop();
      end
    end
  endtask

  // handshakes and outputs at the rising edge, new inputs at the falling edge
  task automatic step();
    @(posedge clk);
    req_fire   = l2tag_req_valid && l2data_req_ready;
    snoop_fire = l2tag_snoop_valid && l2data_snoop_ready;
    if (req_fire) begin
      accept_request();
    end
    if (snoop_fire) begin
      accept_snoop();
    end
    check_outputs();
    @(negedge clk);
    drive_inputs();
  endtask

  task automatic run_until_drained();
    do begin
      step();
    end while ((reqs_left > 0) || (snoops_left > 0) || l2tag_req_valid || l2tag_snoop_valid ||
               (fill_left > 0) || (exp_resp.size() > 0) || (exp_bus_cmd.size() > 0) ||
               (exp_sn_tag.size() > 0) || !l2data_idle);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      stop_run("timeout, traffic did not drain within the cycle limit");
    end
  end

  initial begin
    int round;
    rst                 = 1'b1;
    l2tag_req_valid     = 1'b0;
    l2tag_req_op        = READ;
    l2tag_req_cmd       = BUSRD;
    l2tag_req_addr      = '0;
    l2tag_req_way       = 4'b0001;
    l2tag_req_wmask     = '0;
    l2tag_req_wdata     = '0;
    l2tag_snoop_valid   = 1'b0;
    l2tag_snoop_tag     = '0;
    l2tag_snoop_addr    = '0;
    l2tag_snoop_way     = 4'b0001;
    l2tag_snoop_wen     = 1'b0;
    l2tag_snoop_wdata   = '0;
    l2trans_req_ready   = 1'b1;
    l2trans_snoop_ready = 1'b1;
    resp_ready          = 1'b1;
    fill_left           = 0;
    req_fire            = 1'b0;
    snoop_fire          = 1'b0;
    pf_idx              = 0;
    free_way            = 2'd0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    @(posedge clk);
    check_value("l2_resp_valid", l2_resp_valid, 1'b0);
    check_value("l2data_req_valid", l2data_req_valid, 1'b0);
    check_value("l2data_snoop_valid", l2data_snoop_valid, 1'b0);
    check_value("l2data_req_ready", l2data_req_ready, 1'b1);
    check_value("l2data_snoop_ready", l2data_snoop_ready, 1'b1);
    check_value("l2data_idle", l2data_idle, 1'b1);
    @(negedge clk);

    prefill     = 1'b1;
    reqs_left   = 0;
    snoops_left = 2 * NUM_LINES;
    run_until_drained();

    prefill = 1'b0;
    for (round = 0; round < ROUNDS; round++) begin
      free_way    = 2'(lfsr_bits(2));
      reqs_left   = ROUND_REQS;
      snoops_left = ROUND_SNOOPS;
      run_until_drained();
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- l2data.f
l2data_geom_pkg.sv
l2data_cmd_pkg.sv
l2bank.sv
l2data_issue.sv
l2data_banks.sv
l2data_pipe.sv
l2data.sv
tb_clkgen.sv
l2data_asserts.sv
l2data_tb.sv
